/* project.f */
logic/rvCorePkg.sv
logic/apbBusPkg.sv
logic/apbInstrPort.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/regFile.sv
logic/issueCoreTop.sv
tb/issueCore_asserts.sv
tb/issueCoreTb.sv

/* Bender.yml */
package:
  name: issue_core

sources:
  - logic/rvCorePkg.sv
  - logic/apbBusPkg.sv
  - logic/apbInstrPort.sv
  - logic/decodeStage.sv
  - logic/executeStage.sv
  - logic/regFile.sv
  - logic/issueCoreTop.sv
  - target: simulation
    files:
      - tb/issueCore_asserts.sv
      - tb/issueCoreTb.sv

/* tb/issueCoreTb.sv */
`timescale 1ns/100ps
`default_nettype none

module issueCoreTb;

    // Stimulus sizes
    localparam int shiftAmounts = 32;
    localparam int chainLength  = 12;
    // Upper bound on APB transfers, summed test by test
    localparam int transfers    = 60 + (20 + shiftAmounts * 7) + 2 * chainLength + 10 + 10 + 12;
    localparam int cycleLimit   = 20 * transfers + 200;

    // One pending readback
    typedef struct packed {
        apbBusPkg::apbAddr addr;
        logic              err;
        rvCorePkg::word    value;
    } expectEntry;

    logic             clk;
    logic             rstN;
    apbBusPkg::apbReq req;
    apbBusPkg::apbRsp rsp;

    // Reference model state
    rvCorePkg::word refRegs [rvCorePkg::regCount];
    rvCorePkg::word refPc;

    expectEntry pending [$];
    logic       checkReq;
    string      testName;
    int         seed;
    int         checkCount = 0;
    int         errorCount = 0;
    int         testChecks;
    int         testErrors;
    int         cycles = 0;

    issueCoreTop DUT (
        .clk  (clk),
        .rstN (rstN),
        .req  (req),
        .rsp  (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
            $display("Simulation failed");
            $finish;
        end
    end

    ////////////////////
    // Encoders
    ////////////////////

    function automatic rvCorePkg::word encodeR(input logic [6:0] f7, input rvCorePkg::regIdx rs2,
            input rvCorePkg::regIdx rs1, input logic [2:0] f3, input rvCorePkg::regIdx rd);
        return {f7, rs2, rs1, f3, rd, rvCorePkg::opOp};
    endfunction

    // Op index 0 to 7 is funct3, 8 is SUB, 9 is SRA
    function automatic rvCorePkg::word encodeROp(input int k, input rvCorePkg::regIdx rs1,
            input rvCorePkg::regIdx rs2, input rvCorePkg::regIdx rd);
        logic [2:0] f3;
        f3 = (k == 8) ? 3'd0 : (k == 9) ? 3'd5 : 3'(k);
        return encodeR((k >= 8) ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
    endfunction

    function automatic rvCorePkg::word encodeI(input logic [11:0] imm, input rvCorePkg::regIdx rs1,
            input logic [2:0] f3, input rvCorePkg::regIdx rd);
        return {imm, rs1, f3, rd, rvCorePkg::opOpImm};
    endfunction

    function automatic rvCorePkg::word encodeU(input logic [19:0] upper,
            input rvCorePkg::regIdx rd);
        return {upper, rd, rvCorePkg::opLui};
    endfunction

    // Offset bit 0 is dropped by the format
    function automatic rvCorePkg::word encodeJ(input logic [20:0] off, input rvCorePkg::regIdx rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, rvCorePkg::opJal};
    endfunction

    function automatic apbBusPkg::apbAddr regAddr(input rvCorePkg::regIdx idx);
        return apbBusPkg::regBase + {1'b0, idx, 2'b00};
    endfunction

    // One of the registers loaded in the first test
    function automatic rvCorePkg::regIdx randomSrc();
        rvCorePkg::word r;
        r = $random(seed);
        return 5'(1 + r[7:0] % 10);
    endfunction

    ////////////////////
    // Reference model
    ////////////////////

    function automatic rvCorePkg::word aluModel(input logic [2:0] f3, input logic alt,
            input rvCorePkg::word a, input rvCorePkg::word b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0:    return alt ? a + ~b + 32'd1 : a + b;
            3'd1:    return a << sh;
            // Differing signs decide, else unsigned order holds
            3'd2:    return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            // Fill vacated top bits with the sign on SRA
            3'd5:    return alt ? (a >> sh) | (~(32'hFFFF_FFFF >> sh) & {32{a[31]}}) : a >> sh;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Retires one instruction in the model, returns rd afterwards
    function automatic rvCorePkg::word refExec(input rvCorePkg::word instr);
        rvCorePkg::regIdx rd;
        rvCorePkg::word   a;
        rvCorePkg::word   iImm;
        rvCorePkg::word   jImm;
        rvCorePkg::word   result;
        logic             writes;
        logic             jump;
        rd     = instr[11:7];
        a      = refRegs[instr[19:15]];
        iImm   = {{20{instr[31]}}, instr[31:20]};
        jImm   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        writes = 1'b1;
        jump   = 1'b0;
        result = '0;
        case (instr[6:0])
            rvCorePkg::opOp: begin
                result = aluModel(instr[14:12], instr[30], a, refRegs[instr[24:20]]);
            end
            rvCorePkg::opOpImm: begin
                // Only SRAI uses bit 30
                result = aluModel(instr[14:12], instr[30] && (instr[14:12] == 3'd5), a, iImm);
            end
            rvCorePkg::opLui: result = {instr[31:12], 12'h000};
            rvCorePkg::opJal: begin
                result = refPc + 32'd4;
                jump   = 1'b1;
            end
            // Anything else is a bubble
            default: writes = 1'b0;
        endcase
        if (writes && rd != 5'd0) begin
            refRegs[rd] = result;
        end
        refPc = jump ? refPc + jImm : refPc + 32'd4;
        return refRegs[rd];
    endfunction

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic checkWord(input string what, input rvCorePkg::word expected,
            input rvCorePkg::word actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("mismatch %s %s: expected %h actual %h", testName, what, expected, actual);
        end
    endtask

    task automatic checkErr(input string what, input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("mismatch %s %s pslverr: expected %b actual %b", testName, what, expected,
                     actual);
        end
    endtask

    ////////////////////
    // APB driver
    ////////////////////

    // Entered on a falling edge, returns on one with the bus idle
    task automatic apbTransfer(input logic write, input apbBusPkg::apbAddr addr,
            input rvCorePkg::word wdata, output rvCorePkg::word rdata, output logic err);
        // Setup phase
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.pwrite  = write;
        req.paddr   = addr;
        req.pwdata  = wdata;
        @(negedge clk);
        req.penable = 1'b1;
        // Wait states while the pipe drains
        while (!rsp.pready) begin
            @(negedge clk);
        end
        rdata = rsp.prdata;
        err   = rsp.pslverr;
        // Completing rising edge lies in between
        @(negedge clk);
        req.psel    = 1'b0;
        req.penable = 1'b0;
    endtask

    task automatic apbWrite(input apbBusPkg::apbAddr addr, input rvCorePkg::word data,
            output logic err);
        rvCorePkg::word unused;
        apbTransfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apbRead(input apbBusPkg::apbAddr addr, output rvCorePkg::word data,
            output logic err);
        apbTransfer(1'b0, addr, '0, data, err);
    endtask

    ////////////////////
    // Sequencing
    ////////////////////

    // Later expectations for the same address replace earlier ones
    task automatic expectAt(input apbBusPkg::apbAddr addr, input rvCorePkg::word value,
            input logic err);
        int i;
        for (i = pending.size() - 1; i >= 0; i--) begin
            if (pending[i].addr == addr) begin
                pending.delete(i);
            end
        end
        pending.push_back('{addr: addr, err: err, value: value});
    endtask

    task automatic issue(input rvCorePkg::word instr);
        rvCorePkg::word expected;
        logic           err;
        expected = refExec(instr);
        apbWrite(apbBusPkg::instrAddr, instr, err);
        checkErr("instruction write", 1'b0, err);
        expectAt(regAddr(instr[11:7]), expected, 1'b0);
    endtask

    // Hand the pending reads to the compare process and wait
    task automatic runChecks();
        expectAt(apbBusPkg::pcAddr, refPc, 1'b0);
        checkReq = 1'b1;
        wait (!checkReq);
    endtask

    task automatic startTest(input string name);
        testName   = name;
        testChecks = checkCount;
        testErrors = errorCount;
    endtask

    task automatic endTest();
        $display("test %s: %0d checks, %0d errors", testName, checkCount - testChecks,
                 errorCount - testErrors);
    endtask

    // Compare process, reads back everything pending
    initial begin : compare
        expectEntry     e;
        rvCorePkg::word data;
        logic           err;
        forever begin
            wait (checkReq);
            while (pending.size() > 0) begin
                e = pending.pop_front();
                apbRead(e.addr, data, err);
                checkErr($sformatf("read %h", e.addr), e.err, err);
                if (!e.err) begin
                    checkWord($sformatf("read %h", e.addr), e.value, data);
                end
            end
            checkReq = 1'b0;
        end
    end

    initial begin : stimulus
        rvCorePkg::word   r;
        rvCorePkg::word   r2;
        rvCorePkg::regIdx prev;
        rvCorePkg::regIdx prev2;
        rvCorePkg::regIdx cur;
        logic             err;
        int               i;
        int               k;
        int               sh;
        int               totalErrors;
        seed       = 32'h7f8b1b19;
        req        = '0;
        rstN       = 1'b0;
        checkReq   = 1'b0;
        refRegs[0] = '0;
        refPc      = '0;
        repeat (8) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);

        // R-type on random operands
        startTest("rtype");
        for (i = 1; i <= 10; i++) begin
            r  = $random(seed);
            r2 = $random(seed);
            issue(encodeU(r[19:0], 5'(i)));
            issue(encodeI(r2[11:0], 5'(i), 3'd0, 5'(i)));
        end
        for (k = 0; k < 10; k++) begin
            issue(encodeROp(k, randomSrc(), randomSrc(), 5'(11 + k)));
        end
        runChecks();
        endTest();

        // I-type, shifts over every amount from a negative source
        startTest("itype");
        for (k = 0; k < 8; k++) begin
            if (k != 1 && k != 5) begin
                r = $random(seed);
                issue(encodeI(r[11:0], randomSrc(), 3'(k), 5'(11 + k)));
            end
        end
        r  = $random(seed);
        r2 = $random(seed);
        issue(encodeU({1'b1, r[18:0]}, 5'd24));
        issue(encodeI(r2[11:0], 5'd24, 3'd6, 5'd24));
        for (sh = 0; sh < shiftAmounts; sh++) begin
            issue(encodeI({7'h00, 5'(sh)}, 5'd24, 3'd1, 5'd21));
            issue(encodeI({7'h00, 5'(sh)}, 5'd24, 3'd5, 5'd22));
            issue(encodeI({7'h20, 5'(sh)}, 5'd24, 3'd5, 5'd23));
            runChecks();
        end
        endTest();

        // Dependent chain, each op reads the last two results
        startTest("bypass");
        prev  = 5'd3;
        prev2 = 5'd4;
        for (k = 0; k < chainLength; k++) begin
            r   = $random(seed);
            cur = 5'(27 + k % 5);
            issue(encodeROp(r[7:0] % 10, prev, prev2, cur));
            prev2 = prev;
            prev  = cur;
        end
        runChecks();
        endTest();

        // x0 writes and bubbles
        startTest("x0");
        issue(encodeI(12'd77, 5'd5, 3'd0, 5'd0));
        r = $random(seed);
        issue(encodeU(r[19:0], 5'd0));
        issue(encodeROp(0, 5'd1, 5'd2, 5'd0));
        // Load and system opcodes, rd already holds a value
        issue({12'h004, 5'd1, 3'b010, 5'd5, 7'b0000011});
        issue({12'h000, 5'd0, 3'b000, 5'd6, 7'b1110011});
        runChecks();
        endTest();

        // Link values and PC moves
        startTest("jal");
        r = $random(seed);
        issue(encodeJ({r[20:1], 1'b0}, 5'd25));
        issue(encodeI(12'd8, 5'd25, 3'd0, 5'd26));
        r = $random(seed);
        issue(encodeJ({r[20:1], 1'b0}, 5'd0));
        // Backward jump
        r = $random(seed);
        issue(encodeJ({1'b1, r[19:1], 1'b0}, 5'd1));
        runChecks();
        endTest();

        // Slave errors leave state alone
        startTest("errors");
        r = $random(seed);
        apbWrite(apbBusPkg::pcAddr, r, err);
        checkErr("pc write", 1'b1, err);
        apbWrite(regAddr(5'd7), r, err);
        checkErr("register write", 1'b1, err);
        expectAt(apbBusPkg::instrAddr, '0, 1'b1);
        expectAt(8'h40, '0, 1'b1);
        expectAt(8'h82, '0, 1'b1);
        expectAt(regAddr(5'd7), refRegs[7], 1'b0);
        runChecks();
        // x26 read is the first transfer after this write
        issue(encodeI(12'h5a5, 5'd26, 3'd4, 5'd26));
        runChecks();
        endTest();

        totalErrors = errorCount + DUT.asserts.assertFails;
        $display("%0d checks, %0d mismatches, %0d assertion failures", checkCount, errorCount,
                 DUT.asserts.assertFails);
        if (totalErrors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/issueCore_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module issueCoreAsserts (
    input logic             clk,
    input logic             rstN,
    input apbBusPkg::apbReq req,
    input apbBusPkg::apbRsp rsp,
    input logic             decValid,
    input logic             exValid
);

    // Failure count, read by the testbench at the end of the run
    int assertFails;

    initial assertFails = 0;

    ////////////////////
    // APB protocol
    ////////////////////

    // Once selected, psel stays up until the completing edge
    property pselHeld;
        @(posedge clk) disable iff (!rstN)
        req.psel && !(req.penable && rsp.pready) |=> req.psel;
    endproperty

    // Error flag only in the access phase
    property errInAccess;
        @(posedge clk) disable iff (!rstN)
        rsp.pslverr |-> req.penable;
    endproperty

    ////////////////////
    // Pipeline
    ////////////////////

    // Good read completes only with an empty pipe
    property readDrained;
        @(posedge clk) disable iff (!rstN)
        req.psel && req.penable && !req.pwrite && rsp.pready && !rsp.pslverr
            |-> !decValid && !exValid;
    endproperty

    assert property (pselHeld) else begin
        $error("psel dropped before pready");
        assertFails++;
    end

    assert property (errInAccess) else begin
        $error("pslverr high outside the access phase");
        assertFails++;
    end

    assert property (readDrained) else begin
        $error("read completed with an instruction still in the pipe");
        assertFails++;
    end

endmodule

bind issueCoreTop issueCoreAsserts asserts (
    .clk      (clk),
    .rstN     (rstN),
    .req      (req),
    .rsp      (rsp),
    .decValid (dec.valid),
    .exValid  (res.valid)
);

`default_nettype wire

/* logic/issueCoreTop.sv */
`timescale 1ns/100ps
`default_nettype none

module issueCoreTop (
    input  logic             clk,
    input  logic             rstN,
    input  apbBusPkg::apbReq req,
    output apbBusPkg::apbRsp rsp
);

    // Port to decode
    logic                   issueValid;
    rvCorePkg::word         issueWord;
    logic                   busy;
    // Decode to execute
    rvCorePkg::decodedInstr dec;
    logic                   execValid;
    // Execute and register file
    rvCorePkg::regIdx       rs1;
    rvCorePkg::regIdx       rs2;
    rvCorePkg::word         rdata1;
    rvCorePkg::word         rdata2;
    rvCorePkg::exResult     res;
    rvCorePkg::word         pcVal;
    // Host read path
    rvCorePkg::regIdx       r3;
    rvCorePkg::word         rdata3;

    apbInstrPort port (
        .clk        (clk),
        .rstN       (rstN),
        .req        (req),
        .rsp        (rsp),
        .busy       (busy),
        .pcVal      (pcVal),
        .rdata3     (rdata3),
        .r3         (r3),
        .issueValid (issueValid),
        .issueWord  (issueWord)
    );

    decodeStage decode (
        .clk        (clk),
        .rstN       (rstN),
        .issueValid (issueValid),
        .issueWord  (issueWord),
        .execValid  (execValid),
        .busy       (busy),
        .dec        (dec)
    );

    executeStage execute (
        .clk       (clk),
        .rstN      (rstN),
        .dec       (dec),
        .rs1       (rs1),
        .rs2       (rs2),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .res       (res),
        .pcVal     (pcVal),
        .execValid (execValid)
    );

    regFile regs (
        .clk    (clk),
        .res    (res),
        .rs1    (rs1),
        .rs2    (rs2),
        .r3     (r3),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .rdata3 (rdata3)
    );

endmodule

`default_nettype wire

/* logic/regFile.sv */
`timescale 1ns/100ps
`default_nettype none

module regFile (
    input  logic               clk,
    input  rvCorePkg::exResult res,
    input  rvCorePkg::regIdx   rs1,
    input  rvCorePkg::regIdx   rs2,
    input  rvCorePkg::regIdx   r3,
    output rvCorePkg::word     rdata1,
    output rvCorePkg::word     rdata2,
    output rvCorePkg::word     rdata3
);

    rvCorePkg::word regs [rvCorePkg::regCount];
    rvCorePkg::word wdata;
    logic           wrEn;

    ////////////////////
    // Write-back
    ////////////////////

    // Link value is PC plus 4 of the JAL itself
    assign wdata = (res.sel == rvCorePkg::wbLink) ? res.pcVal + 32'd4 : res.aluOut;
    // x0 is never written
    assign wrEn  = res.valid && res.writeEn && (res.rd != '0);

    always_ff @(posedge clk) begin
        if (wrEn) begin
            regs[res.rd] <= wdata;
        end
    end

    ////////////////////
    // Reads
    ////////////////////

    always_comb begin
        rdata1 = regs[rs1];
        rdata2 = regs[rs2];
        // Host port only reads an idle pipe
        rdata3 = regs[r3];
        // Execute ports see back-to-back results
        if (wrEn && (rs1 == res.rd)) begin
            rdata1 = wdata;
        end
        if (wrEn && (rs2 == res.rd)) begin
            rdata2 = wdata;
        end
        // Zero for x0
        if (rs1 == '0) begin
            rdata1 = '0;
        end
        if (rs2 == '0) begin
            rdata2 = '0;
        end
        if (r3 == '0) begin
            rdata3 = '0;
        end
    end

endmodule

`default_nettype wire

/* logic/executeStage.sv */
`timescale 1ns/100ps
`default_nettype none

module executeStage (
    input  logic                   clk,
    input  logic                   rstN,
    input  rvCorePkg::decodedInstr dec,
    output rvCorePkg::regIdx       rs1,
    output rvCorePkg::regIdx       rs2,
    input  rvCorePkg::word         rdata1,
    input  rvCorePkg::word         rdata2,
    output rvCorePkg::exResult     res,
    output rvCorePkg::word         pcVal,
    output logic                   execValid
);

    rvCorePkg::word opA;
    rvCorePkg::word opB;
    rvCorePkg::word aluOut;
    rvCorePkg::word pcQ;

    ////////////////////
    // Operands
    ////////////////////

    // Register reads happen in the same cycle
    assign rs1 = dec.rs1;
    assign rs2 = dec.rs2;
    assign opA = rdata1;
    assign opB = dec.useImm ? dec.imm : rdata2;

    ////////////////////
    // ALU
    ////////////////////

    always_comb begin
        case (dec.op)
            rvCorePkg::aluAdd:   aluOut = opA + opB;
            rvCorePkg::aluSub:   aluOut = opA - opB;
            rvCorePkg::aluSll:   aluOut = opA << opB[4:0];
            rvCorePkg::aluSlt:   aluOut = {31'b0, $signed(opA) < $signed(opB)};
            rvCorePkg::aluSltu:  aluOut = {31'b0, opA < opB};
            rvCorePkg::aluXor:   aluOut = opA ^ opB;
            rvCorePkg::aluSrl:   aluOut = opA >> opB[4:0];
            // Arithmetic shift keeps the sign
            rvCorePkg::aluSra:   aluOut = $signed(opA) >>> opB[4:0];
            rvCorePkg::aluOr:    aluOut = opA | opB;
            rvCorePkg::aluAnd:   aluOut = opA & opB;
            default:             aluOut = opB;
        endcase
    end

    // Execute register, tagged with the PC of this instruction
    always_ff @(posedge clk) begin
        if (!rstN) begin
            res.valid <= 1'b0;
        end else begin
            res.valid   <= dec.valid;
            res.rd      <= dec.rd;
            res.writeEn <= dec.writeEn;
            res.sel     <= dec.sel;
            res.aluOut  <= aluOut;
            res.pcVal   <= pcQ;
        end
    end

    // PC moves by 4, or by the offset on JAL
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pcQ <= '0;
        end else if (dec.valid) begin
            pcQ <= dec.isJal ? pcQ + dec.imm : pcQ + 32'd4;
        end
    end

    assign pcVal     = pcQ;
    assign execValid = res.valid;

endmodule

`default_nettype wire

/* logic/decodeStage.sv */
`timescale 1ns/100ps
`default_nettype none

module decodeStage (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   issueValid,
    input  rvCorePkg::word         issueWord,
    input  logic                   execValid,
    output logic                   busy,
    output rvCorePkg::decodedInstr dec
);

    rvCorePkg::decodedInstr decNext;
    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic                   shiftOk;
    logic                   supported;

    // Instruction fields
    assign opcode  = issueWord[6:0];
    assign funct3  = issueWord[14:12];
    assign funct7  = issueWord[31:25];
    // Only plain and arithmetic encodings of funct7 exist
    assign shiftOk = (funct7 == 7'h00) || (funct7 == 7'h20);

    // funct3 to ALU op, alt picks SUB and SRA
    function automatic rvCorePkg::aluOp aluFromFunct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rvCorePkg::aluSub : rvCorePkg::aluAdd;
            3'b001:  return rvCorePkg::aluSll;
            3'b010:  return rvCorePkg::aluSlt;
            3'b011:  return rvCorePkg::aluSltu;
            3'b100:  return rvCorePkg::aluXor;
            3'b101:  return alt ? rvCorePkg::aluSra : rvCorePkg::aluSrl;
            3'b110:  return rvCorePkg::aluOr;
            default: return rvCorePkg::aluAnd;
        endcase
    endfunction

    always_comb begin
        decNext        = '0;
        decNext.valid  = issueValid;
        decNext.rd     = issueWord[11:7];
        decNext.rs1    = issueWord[19:15];
        decNext.rs2    = issueWord[24:20];
        // I immediate by default, shamt sits in its low bits
        decNext.imm    = {{20{issueWord[31]}}, issueWord[31:20]};
        decNext.useImm = 1'b1;
        decNext.op     = rvCorePkg::aluAdd;
        decNext.sel    = rvCorePkg::wbAlu;
        supported      = 1'b0;
        case (opcode)
            rvCorePkg::opOp: begin
                decNext.useImm = 1'b0;
                decNext.op     = aluFromFunct(funct3, funct7[5]);
                supported      = (funct7 == 7'h00) ||
                                 ((funct7 == 7'h20) && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            rvCorePkg::opOpImm: begin
                // ADDI has no subtract form
                decNext.op = aluFromFunct(funct3, funct7[5] && (funct3 == 3'b101));
                if (funct3 == 3'b001) begin
                    supported = funct7 == 7'h00;
                end else if (funct3 == 3'b101) begin
                    supported = shiftOk;
                end else begin
                    supported = 1'b1;
                end
            end
            rvCorePkg::opLui: begin
                decNext.imm = {issueWord[31:12], 12'b0};
                decNext.op  = rvCorePkg::aluPassB;
                supported   = 1'b1;
            end
            rvCorePkg::opJal: begin
                // J immediate
                decNext.imm   = {{12{issueWord[31]}}, issueWord[19:12], issueWord[20],
                                 issueWord[30:21], 1'b0};
                decNext.sel   = rvCorePkg::wbLink;
                decNext.isJal = 1'b1;
                supported     = 1'b1;
            end
            default: supported = 1'b0;
        endcase
        // Bubble when unsupported or rd is x0
        decNext.writeEn = supported && (decNext.rd != '0);
    end

    // Decode register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            dec.valid <= 1'b0;
        end else begin
            dec <= decNext;
        end
    end

    // Anything still in decode or write-back
    assign busy = dec.valid || execValid;

endmodule

`default_nettype wire

/* logic/apbInstrPort.sv */
`timescale 1ns/100ps
`default_nettype none

module apbInstrPort (
    input  logic              clk,
    input  logic              rstN,
    input  apbBusPkg::apbReq  req,
    output apbBusPkg::apbRsp  rsp,
    input  logic              busy,
    input  rvCorePkg::word    pcVal,
    input  rvCorePkg::word    rdata3,
    output rvCorePkg::regIdx  r3,
    output logic              issueValid,
    output rvCorePkg::word    issueWord
);

    typedef enum logic {
        portIdle,
        portAccess
    } portState;

    portState       state;
    logic           readyQ;
    logic           slvErrQ;
    rvCorePkg::word rdataQ;
    logic           isInstr;
    logic           isPc;
    logic           isReg;
    logic           reqErr;

    ////////////////////
    // Address decode
    ////////////////////

    assign isInstr = req.paddr == apbBusPkg::instrAddr;
    assign isPc    = req.paddr == apbBusPkg::pcAddr;
    // Word aligned and in the upper half
    assign isReg   = (req.paddr & 8'h83) == apbBusPkg::regBase;
    assign reqErr  = req.pwrite ? !isInstr : !(isPc || isReg);

    // Third read port index straight from the address
    assign r3 = req.paddr[6:2];

    // One pulse on the completing write edge
    assign issueValid = (state == portAccess) && req.psel && req.penable && req.pwrite &&
                        readyQ && !slvErrQ;
    assign issueWord  = req.pwdata;

    ////////////////////
    // Transfer FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state   <= portIdle;
            readyQ  <= 1'b0;
            slvErrQ <= 1'b0;
        end else begin
            case (state)
                portIdle: begin
                    // Setup phase
                    if (req.psel && !req.penable) begin
                        state   <= portAccess;
                        // Writes and errors never wait
                        readyQ  <= req.pwrite || reqErr || !busy;
                        slvErrQ <= reqErr;
                    end
                end
                portAccess: begin
                    if (!req.psel || (req.penable && readyQ)) begin
                        state   <= portIdle;
                        readyQ  <= 1'b0;
                        slvErrQ <= 1'b0;
                    end else begin
                        // Read waits for an empty pipe
                        readyQ <= !busy;
                    end
                end
                default: state <= portIdle;
            endcase
        end
    end

    // Read data sampled every cycle, stable once pipe drains
    always_ff @(posedge clk) begin
        rdataQ <= isPc ? pcVal : rdata3;
    end

    assign rsp = '{pready: readyQ, prdata: rdataQ, pslverr: slvErrQ};

endmodule

`default_nettype wire

/* logic/apbBusPkg.sv */
`default_nettype none

package apbBusPkg;

    // Byte address on the APB side
    typedef logic [7:0] apbAddr;

    // Host to core
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        apbAddr      paddr;
        logic [31:0] pwdata;
    } apbReq;

    // Core to host
    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
        logic        pslverr;
    } apbRsp;

    ////////////////////
    // Address map
    ////////////////////

    // Instruction push, write only
    localparam apbAddr instrAddr = 8'h00;
    // Current PC, read only
    localparam apbAddr pcAddr    = 8'h04;
    // x0 to x31 at regBase plus 4 times index
    localparam apbAddr regBase   = 8'h80;

endpackage

`default_nettype wire

/* logic/rvCorePkg.sv */
`default_nettype none

package rvCorePkg;

    // Register file depth
    localparam int regCount = 32;

    ////////////////////
    // Base types
    ////////////////////

    // Data, PC and instruction words
    typedef logic [31:0] word;
    // Register index
    typedef logic [4:0]  regIdx;

    // Major opcodes handled by the core
    localparam logic [6:0] opOp    = 7'b0110011;
    localparam logic [6:0] opOpImm = 7'b0010011;
    localparam logic [6:0] opLui   = 7'b0110111;
    localparam logic [6:0] opJal   = 7'b1101111;

    // ALU operations, passB forwards operand B for LUI
    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu,
        aluXor, aluSrl, aluSra, aluOr, aluAnd, aluPassB
    } aluOp;

    // Write-back source
    typedef enum logic {
        wbAlu,
        wbLink
    } wbSel;

    ////////////////////
    // Stage structs
    ////////////////////

    // Decode register contents
    typedef struct packed {
        logic  valid;
        regIdx rd;
        regIdx rs1;
        regIdx rs2;
        logic  useImm;
        word   imm;
        aluOp  op;
        wbSel  sel;
        logic  writeEn;
        logic  isJal;
    } decodedInstr;

    // Execute register contents, pcVal not yet incremented
    typedef struct packed {
        logic  valid;
        regIdx rd;
        logic  writeEn;
        wbSel  sel;
        word   aluOut;
        word   pcVal;
    } exResult;

endpackage

`default_nettype wire
